/* hw/isa_pkg.sv */
// Instruction-level types for the ALU core; imported by the RTL and by the testbench
package isa_pkg;

  //////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////

  typedef logic [4:0]  arch_reg_t;  // 32 architectural registers, r0 reads zero
  typedef logic [31:0] data_t;      // Data word
  typedef logic [15:0] imm_t;       // Immediate, sign-extended at use

  //////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////

  // Shift amounts come from the low 5 bits of operand b
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,  // Shift left logical
    ALU_SRL  = 3'd6,  // Shift right logical
    ALU_SLTU = 3'd7   // Set less than, unsigned
  } alu_func_e;

  //////////////////////////////////////////////////
  // Decoded operation at dispatch
  //////////////////////////////////////////////////

  // One already-decoded ALU operation as offered to the core
  typedef struct packed {
    alu_func_e alu_func;
    arch_reg_t dest;      // r0 means result is dropped
    arch_reg_t src_a;
    arch_reg_t src_b;     // Ignored when use_imm is set
    logic      use_imm;   // Operand b from imm
    imm_t      imm;
  } dispatch_op_t;

  // Immediate widened to a data word
  function automatic data_t sign_extend(imm_t imm);
    return {{16{imm[15]}}, imm};
  endfunction

endpackage

/* hw/ooo_pkg.sv */
// Microarchitecture types of the out-of-order core: tags, operands, CDB and issue payload
package ooo_pkg;

  import isa_pkg::*;

  //////////////////////////////////////////////////
  // Station sizing
  //////////////////////////////////////////////////

  localparam int DEFAULT_NUM_RS = 4;
  localparam int MAX_NUM_RS     = 8;  // Bounded by the tag width

  // Producer tag is simply the station slot number
  typedef logic [$clog2(MAX_NUM_RS)-1:0] rs_tag_t;

  //////////////////////////////////////////////////
  // Datapath structs
  //////////////////////////////////////////////////

  // Renamed source operand; value only meaningful when ready
  typedef struct packed {
    logic    ready;
    rs_tag_t tag;    // Producer to wait for
    data_t   value;
  } operand_t;

  // Common data bus, one result per cycle
  typedef struct packed {
    logic    valid;
    rs_tag_t tag;
    data_t   value;
  } cdb_t;

  // Station to ALU
  typedef struct packed {
    logic      valid;
    rs_tag_t   tag;
    alu_func_e alu_func;
    data_t     opa;
    data_t     opb;
  } issue_t;

endpackage

/* hw/map_table.sv */
// Register map table: architectural values with producer tags, renames at dispatch, retires from the CDB
`timescale 1ns/10ps

module map_table
  import isa_pkg::*, ooo_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_fire,  // Op accepted this cycle
  input  dispatch_op_t dispatch_op,
  input  rs_tag_t      alloc_tag,      // Slot the op goes to
  input  cdb_t         cdb,
  output operand_t     opa,
  output operand_t     opb,
  input  arch_reg_t    read_idx,
  output data_t        read_data,
  output logic         any_busy        // Some register awaits a result
);

  data_t      reg_value [32];
  logic [31:0] reg_busy;   // Producer still outstanding
  rs_tag_t    reg_tag [32];

  //////////////////////////////////////////////////
  // Source lookup
  //////////////////////////////////////////////////

  // Register, then CDB bypass, else wait on tag
  function automatic operand_t resolve_source(arch_reg_t idx);
    operand_t op;
    op.ready = 1'b1;
    op.tag   = reg_tag[idx];
    op.value = reg_value[idx];
    if (idx == '0) begin
      op.value = '0;  // r0 hardwired
    end else if (reg_busy[idx]) begin
      if (cdb.valid && cdb.tag == reg_tag[idx]) begin
        op.value = cdb.value;  // Result arriving right now
      end else begin
        op.ready = 1'b0;
      end
    end
    return op;
  endfunction

  always_comb begin
    opa = resolve_source(dispatch_op.src_a);
    opb = resolve_source(dispatch_op.src_b);
    if (dispatch_op.use_imm) begin
      opb.ready = 1'b1;
      opb.tag   = '0;
      opb.value = sign_extend(dispatch_op.imm);
    end
  end

  //////////////////////////////////////////////////
  // Retire and rename
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      reg_busy <= '0;
      for (int i = 0; i < 32; i++) begin
        reg_value[i] <= '0;
        reg_tag[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < 32; i++) begin
        // Only the latest producer may write, so WAW is safe
        if (cdb.valid && reg_busy[i] && reg_tag[i] == cdb.tag) begin
          reg_value[i] <= cdb.value;
          reg_busy[i]  <= 1'b0;
        end
      end
      // Rename wins over a same-cycle retire of the destination
      if (dispatch_fire && dispatch_op.dest != '0) begin
        reg_busy[dispatch_op.dest] <= 1'b1;
        reg_tag[dispatch_op.dest]  <= alloc_tag;
      end
    end
  end

  assign read_data = reg_value[read_idx];  // Stored value, busy or not
  assign any_busy  = |reg_busy;

endmodule

/* hw/reservation_station.sv */
// Reservation station: slot allocation, CDB wakeup and lowest-index issue of ready entries
`timescale 1ns/10ps

module reservation_station
  import isa_pkg::*, ooo_pkg::*;
#(
  parameter int NUM_RS = DEFAULT_NUM_RS  // 2 .. MAX_NUM_RS
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_valid,
  output logic      dispatch_ready,  // Free slot available
  input  alu_func_e alu_func,
  input  operand_t  opa,
  input  operand_t  opb,
  input  cdb_t      cdb,
  output rs_tag_t   alloc_tag,       // Lowest free slot
  output issue_t    issue,
  output logic      slots_busy
);

  // Payload of one slot
  typedef struct packed {
    alu_func_e alu_func;
    operand_t  opa;
    operand_t  opb;
  } rs_entry_t;

  logic [NUM_RS-1:0] slot_busy;
  rs_entry_t         entries [NUM_RS];
  logic [NUM_RS-1:0] slot_ready;   // Busy with both operands present
  rs_tag_t           issue_idx;
  logic              have_free;
  logic              dispatch_fire;

  //////////////////////////////////////////////////
  // Allocation and issue select
  //////////////////////////////////////////////////

  always_comb begin
    alloc_tag = '0;
    have_free = 1'b0;
    issue_idx = '0;
    // Walk downward so the lowest index is the last one kept
    for (int i = NUM_RS - 1; i >= 0; i--) begin
      slot_ready[i] = slot_busy[i] && entries[i].opa.ready && entries[i].opb.ready;
      if (!slot_busy[i]) begin
        alloc_tag = rs_tag_t'(i);
        have_free = 1'b1;
      end
      if (slot_ready[i]) begin
        issue_idx = rs_tag_t'(i);
      end
    end
  end

  assign dispatch_ready = have_free;
  assign dispatch_fire  = dispatch_valid & dispatch_ready;
  assign slots_busy     = |slot_busy;

  always_comb begin
    issue          = '0;
    issue.valid    = |slot_ready;
    issue.tag      = issue_idx;
    for (int i = 0; i < NUM_RS; i++) begin
      if (issue_idx == rs_tag_t'(i)) begin
        issue.alu_func = entries[i].alu_func;
        issue.opa      = entries[i].opa.value;
        issue.opb      = entries[i].opb.value;
      end
    end
  end

  //////////////////////////////////////////////////
  // Slot state
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_busy <= '0;
    end else begin
      for (int i = 0; i < NUM_RS; i++) begin
        if (issue.valid && issue_idx == rs_tag_t'(i)) slot_busy[i] <= 1'b0;  // Freed on issue
        if (dispatch_fire && alloc_tag == rs_tag_t'(i)) slot_busy[i] <= 1'b1;
      end
    end
  end

  // Capture at dispatch, else pick up CDB results for waiting operands
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_RS; i++) begin
      if (dispatch_fire && alloc_tag == rs_tag_t'(i)) begin
        entries[i].alu_func <= alu_func;
        entries[i].opa      <= opa;
        entries[i].opb      <= opb;
      end else if (slot_busy[i] && cdb.valid) begin
        if (!entries[i].opa.ready && entries[i].opa.tag == cdb.tag) begin
          entries[i].opa.ready <= 1'b1;
          entries[i].opa.value <= cdb.value;
        end
        if (!entries[i].opb.ready && entries[i].opb.tag == cdb.tag) begin
          entries[i].opb.ready <= 1'b1;
          entries[i].opb.value <= cdb.value;
        end
      end
    end
  end

endmodule

/* hw/alu_unit.sv */
// Single-stage integer ALU; turns an issued station entry into next cycle's CDB broadcast
`timescale 1ns/10ps

module alu_unit
  import isa_pkg::*, ooo_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  issue_t issue,
  output cdb_t   cdb     // Registered result
);

  data_t alu_result;

  //////////////////////////////////////////////////
  // Function evaluation
  //////////////////////////////////////////////////

  always_comb begin
    case (issue.alu_func)
      ALU_ADD:  alu_result = issue.opa + issue.opb;
      ALU_SUB:  alu_result = issue.opa - issue.opb;
      ALU_AND:  alu_result = issue.opa & issue.opb;
      ALU_OR:   alu_result = issue.opa | issue.opb;
      ALU_XOR:  alu_result = issue.opa ^ issue.opb;
      ALU_SLL:  alu_result = issue.opa << issue.opb[4:0];
      ALU_SRL:  alu_result = issue.opa >> issue.opb[4:0];
      ALU_SLTU: alu_result = data_t'(issue.opa < issue.opb);
      default:  alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result register, drives the CDB
  //////////////////////////////////////////////////

  // New issue every cycle, no stall path
  always_ff @(posedge clock) begin
    cdb.tag   <= issue.tag;
    cdb.value <= alu_result;
    if (reset) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= issue.valid;  // One broadcast per issue
    end
  end

endmodule

/* hw/ooo_core.sv */
// Top of the out-of-order ALU core; connects map table, reservation station and ALU
`timescale 1ns/10ps

module ooo_core
  import isa_pkg::*, ooo_pkg::*;
#(
  parameter int NUM_RS = DEFAULT_NUM_RS
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_valid,
  input  dispatch_op_t dispatch_op,
  output logic         dispatch_ready,
  input  arch_reg_t    read_idx,
  output data_t        read_data,
  output logic         idle            // Nothing in flight
);

  operand_t opa;
  operand_t opb;
  rs_tag_t  alloc_tag;
  issue_t   issue;
  cdb_t     cdb;
  logic     any_busy;
  logic     slots_busy;
  logic     dispatch_fire;

  assign dispatch_fire = dispatch_valid & dispatch_ready;  // Handshake done
  assign idle = ~(any_busy | slots_busy | issue.valid | cdb.valid);

  //////////////////////////////////////////////////
  // Rename, hold, execute
  //////////////////////////////////////////////////

  map_table u_map_table (
    .clock         (clock),
    .reset         (reset),
    .dispatch_fire (dispatch_fire),
    .dispatch_op   (dispatch_op),
    .alloc_tag     (alloc_tag),
    .cdb           (cdb),
    .opa           (opa),
    .opb           (opb),
    .read_idx      (read_idx),
    .read_data     (read_data),
    .any_busy      (any_busy)
  );

  reservation_station #(.NUM_RS(NUM_RS)) u_reservation_station (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .alu_func       (dispatch_op.alu_func),
    .opa            (opa),
    .opb            (opb),
    .cdb            (cdb),
    .alloc_tag      (alloc_tag),
    .issue          (issue),
    .slots_busy     (slots_busy)
  );

  alu_unit u_alu_unit (
    .clock (clock),
    .reset (reset),
    .issue (issue),
    .cdb   (cdb)     // Back to station and map table
  );

endmodule

/* testbench/tb_program.svh */
// Stimulus table and random program generator; included inside the ooo_core_tb module

// One offered operation with its timing and check point
typedef struct {
  dispatch_op_t op;
  int           gap;    // Idle cycles before the op is offered
  bit           check;  // Wait for idle and compare every register
} program_row_t;

program_row_t program_rows [$];
int           stall_row;  // Check point that closes the back-pressure chain

task automatic add_row(alu_func_e func, int dest, int src_a, int src_b, bit use_imm,
                       int imm, int gap, bit check);
  program_row_t row;
  row.op.alu_func = func;
  row.op.dest     = arch_reg_t'(dest);
  row.op.src_a    = arch_reg_t'(src_a);
  row.op.src_b    = arch_reg_t'(src_b);
  row.op.use_imm  = use_imm;
  row.op.imm      = imm_t'(imm);
  row.gap         = gap;
  row.check       = check;
  program_rows.push_back(row);
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift(logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

task automatic build_program();
  logic [31:0] rnd;
  logic [31:0] fields;
  rnd = 32'h554f_883d;
  // Independent ops from immediates with the last aimed at r0
  add_row(ALU_ADD, 1, 0, 0, 1, 'h0011, 0, 0);
  add_row(ALU_ADD, 2, 0, 0, 1, 'hfff0, 0, 0);  // Negative imm
  add_row(ALU_ADD, 3, 0, 0, 1, 'h1234, 0, 0);
  add_row(ALU_XOR, 0, 0, 0, 1, 'h00ff, 0, 1);
  // Every function on settled registers
  add_row(ALU_ADD, 4, 1, 3, 0, 0, 0, 0);
  add_row(ALU_SUB, 5, 1, 2, 0, 0, 1, 0);
  add_row(ALU_AND, 6, 2, 3, 0, 0, 0, 0);
  add_row(ALU_OR, 7, 1, 3, 0, 0, 0, 0);
  add_row(ALU_XOR, 8, 2, 3, 0, 0, 2, 0);
  add_row(ALU_SLL, 9, 3, 0, 1, 'h0004, 0, 0);
  add_row(ALU_SRL, 10, 2, 0, 1, 'h0024, 0, 0);  // Only low 5 bits count
  add_row(ALU_SLTU, 11, 1, 2, 0, 0, 0, 0);
  add_row(ALU_SLTU, 0, 2, 0, 1, 'h0001, 0, 1);
  // RAW chains with own destination and CDB bypass
  add_row(ALU_ADD, 12, 1, 0, 1, 'h0001, 0, 0);
  add_row(ALU_ADD, 13, 12, 12, 0, 0, 0, 0);
  add_row(ALU_SLL, 14, 13, 1, 0, 0, 0, 0);
  add_row(ALU_ADD, 12, 12, 0, 1, 'h0005, 0, 0);
  add_row(ALU_ADD, 15, 0, 0, 1, 'h0007, 0, 0);
  add_row(ALU_SUB, 16, 15, 0, 1, 'h0002, 2, 1);  // Lands in the producer's CDB cycle
  // Slow dependent write to r19 then a fast independent one
  add_row(ALU_ADD, 17, 0, 0, 1, 'h0003, 0, 0);
  add_row(ALU_ADD, 18, 17, 17, 0, 0, 0, 0);
  add_row(ALU_SUB, 19, 18, 17, 0, 0, 0, 0);
  add_row(ALU_OR, 19, 0, 0, 1, 'h5a5a, 0, 1);
  // Long serial chain fills the station
  for (int i = 0; i < 10; i++) begin
    add_row(ALU_ADD, 20, 20, 0, 1, 'h0001, 0, i == 9);
  end
  stall_row = program_rows.size() - 1;
  // Random program checked once at the end
  for (int i = 0; i < 60; i++) begin
    rnd    = xorshift(rnd);
    fields = rnd;
    rnd    = xorshift(rnd);
    add_row(alu_func_e'(fields[2:0]), fields[7:3], fields[12:8], fields[17:13], fields[18],
            rnd[15:0], fields[20:19], i == 59);
  end
endtask

/* testbench/ooo_core_tb.sv */
// Self-checking testbench for the out-of-order ALU core; compile with the build.f file list
`timescale 1ns/10ps

module ooo_core_tb
  import isa_pkg::*, ooo_pkg::*;
();

  localparam int DRIVE_DELAY     = 2;   // Inputs change after the rising edge
  localparam int SAMPLE_DELAY    = 16;  // From drive point to just before the next edge
  localparam int RESET_CYCLES    = 4;
  localparam int CYCLES_PER_ROW  = 60;  // Watchdog budget

  logic         clock;
  logic         reset;
  logic         dispatch_valid;
  dispatch_op_t dispatch_op;
  logic         dispatch_ready;
  arch_reg_t    read_idx;
  data_t        read_data;
  logic         idle;

  data_t model_regs [32];  // Sequential reference, r0 never written
  int    error_count;
  bit    saw_stall;        // dispatch_ready seen low while offering
  bit    program_ready;

  `include "tb_program.svh"

  ooo_core #(.NUM_RS(4)) dut (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_ready (dispatch_ready),
    .read_idx       (read_idx),
    .read_data      (read_data),
    .idle           (idle)
  );

  always #10 clock = ~clock;  // 20 ns period

  //////////////////////////////////////////////////
  // Compare tasks and reference model
  //////////////////////////////////////////////////

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  function automatic data_t model_result(dispatch_op_t op);
    data_t a;
    data_t b;
    a = model_regs[op.src_a];
    b = op.use_imm ? data_t'($signed(op.imm)) : model_regs[op.src_b];
    case (op.alu_func)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Driver tasks, all start and end at edge + 2 ns
  //////////////////////////////////////////////////

  task automatic offer_op(dispatch_op_t op);
    dispatch_valid = 1'b1;
    dispatch_op    = op;
    #SAMPLE_DELAY;
    while (!dispatch_ready) begin  // Hold the op until a slot frees
      saw_stall = 1'b1;
      @(posedge clock);
      #(DRIVE_DELAY + SAMPLE_DELAY);
    end
    @(posedge clock);  // Transfer edge
    #DRIVE_DELAY;
    dispatch_valid = 1'b0;
    if (op.dest != '0) begin
      model_regs[op.dest] = model_result(op);
    end
  endtask

  task automatic wait_idle();
    #SAMPLE_DELAY;
    while (!idle) begin
      @(posedge clock);
      #(DRIVE_DELAY + SAMPLE_DELAY);
    end
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  // One register per cycle through the read port
  task automatic compare_registers();
    for (int i = 0; i < 32; i++) begin
      read_idx = arch_reg_t'(i);
      #SAMPLE_DELAY;
      check_data($sformatf("r%0d", i), model_regs[i], read_data);
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = '0;
    read_idx       = '0;
    error_count    = 0;
    saw_stall      = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();
    program_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    #SAMPLE_DELAY;
    check_bit("dispatch_ready", 1'b1, dispatch_ready);  // State out of reset
    check_bit("idle", 1'b1, idle);
    @(posedge clock);
    #DRIVE_DELAY;
    compare_registers();
    for (int r = 0; r < program_rows.size(); r++) begin
      repeat (program_rows[r].gap) begin
        @(posedge clock);
        #DRIVE_DELAY;
      end
      offer_op(program_rows[r].op);
      if (program_rows[r].check) begin
        wait_idle();
        compare_registers();
        if (r == stall_row) begin
          check_bit("dispatch_ready fell during chain", 1'b1, saw_stall);
        end
        saw_stall = 1'b0;
      end
    end
    $display("Run complete: %0d errors", error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    wait (program_ready);
    repeat (RESET_CYCLES + CYCLES_PER_ROW * program_rows.size()) @(posedge clock);
    $display("Timeout: the core did not accept or finish the program in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+testbench
hw/isa_pkg.sv
hw/ooo_pkg.sv
hw/map_table.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/ooo_core.sv
testbench/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - hw/isa_pkg.sv
  - hw/ooo_pkg.sv
  - hw/map_table.sv
  - hw/reservation_station.sv
  - hw/alu_unit.sv
  - hw/ooo_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ooo_core_tb.sv
